// File: ecc_ladder.f
hw/ecc_pkg.sv
hw/ecc_scalar_feeder.sv
hw/ecc_program_rom.sv
hw/ecc_ctrl.sv
hw/ecc_field_alu.sv
hw/ecc_ladder_top.sv
bench/ecc_ladder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ladder testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f ecc_ladder.f \
    --top-module ecc_ladder_tb -o ecc_ladder_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ecc_ladder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: bench/ecc_ladder_tb.sv
`timescale 1ns/1ps

module ecc_ladder_tb
    import ecc_pkg::*;
();

    localparam int CLK_PERIOD        = 100;
    localparam int P_MOD             = 251;    // Field prime of the model
    localparam int NUM_RANDOM_KEYGEN = 40;
    localparam int NUM_ADDSUB        = 20;
    localparam int NUM_TESTS         = 1 + NUM_RANDOM_KEYGEN + 3 + NUM_ADDSUB + 1;
    // One digit is two multiplies, a stall line and the branch
    localparam int DIGIT_CYCLES      = 2 * (MULT_DELAY + 3) + LADDER_STALL + 6;
    localparam int CMD_CYCLES        = SCALAR_W * DIGIT_CYCLES + 40;
    localparam int BUSY_LIMIT        = 2 * CMD_CYCLES;
    localparam int IDLE_WATCH        = 20;
    localparam int TEST_CYCLES       = CMD_CYCLES + 60;   // Loads, reads, idle watch
    localparam int WATCHDOG_NS       = 2 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

    logic                 clk;
    logic                 reset_n;
    logic [CMD_W-1:0]     cmd_i;
    logic                 load_i;
    logic [SCALAR_W-1:0]  scalar_i;
    logic [DATA_W-1:0]    base_i;
    logic [DATA_W-1:0]    opb_i;
    logic [RF_ADDR_W-1:0] rd_addr_i;
    logic [DATA_W-1:0]    rd_data_o;
    logic                 busy_o;

    integer seed;
    int     errors;
    int     err_mark;
    int     tests_run;
    int     tests_failed;
    int     last_sum;       // Model results of the latest add/sub command
    int     last_diff;

    ecc_ladder_top uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_i     (cmd_i),
        .load_i    (load_i),
        .scalar_i  (scalar_i),
        .base_i    (base_i),
        .opb_i     (opb_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .busy_o    (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    //------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------
    function automatic int pow_mod(input int b, input int e);
        int r;
        int bb;
        r  = 1;
        bb = b % P_MOD;
        for (int i = 0; i < e; i++)
            r = (r * bb) % P_MOD;
        return r;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    //------------------------------------------------------------
    // Bus helpers
    //------------------------------------------------------------
    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("FAILED at %0t ns: %s, read %0d, expected %0d",
                     $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic load_operands(input logic [7:0] scalar, input logic [7:0] base,
                                 input logic [7:0] opb);
        @(posedge clk);
        load_i   <= 1'b1;
        scalar_i <= scalar;
        base_i   <= base;
        opb_i    <= opb;
        @(posedge clk);
        load_i   <= 1'b0;
    endtask

    // Registered read port returns data one cycle after the address
    task automatic read_reg(input logic [RF_ADDR_W-1:0] addr, output logic [7:0] data);
        @(posedge clk);
        rd_addr_i <= addr;
        @(posedge clk);
        @(negedge clk);
        data = rd_data_o;
    endtask

    // Strobe a command and optionally a second one while busy
    task automatic run_command(input logic [CMD_W-1:0] cmd, input int inject_at,
                               input logic [CMD_W-1:0] inject_cmd);
        int cycles;
        @(posedge clk);
        cmd_i <= cmd;
        @(posedge clk);
        cmd_i <= '0;
        @(negedge clk);
        if (!busy_o) begin
            $display("ERROR at %0t ns: busy_o did not rise after command %0d", $time, cmd);
            errors++;
        end else begin
            cycles = 0;
            while (busy_o && cycles < BUSY_LIMIT) begin
                @(posedge clk);
                cmd_i <= (cycles == inject_at) ? inject_cmd : 3'd0;
                @(negedge clk);
                cycles++;
            end
            if (busy_o) begin
                $display("ERROR at %0t ns: busy_o still high after %0d cycles",
                         $time, cycles);
                errors++;
            end else begin
                @(posedge clk);
                cmd_i <= '0;
                for (int i = 0; i < IDLE_WATCH; i++) begin
                    @(negedge clk);
                    if (busy_o) begin
                        $display("ERROR at %0t ns: busy_o rose again after the command ended",
                                 $time);
                        errors++;
                        break;
                    end
                end
            end
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: mismatch", tests_run, name);
        end
        err_mark = errors;
    endtask

    //------------------------------------------------------------
    // Tests
    //------------------------------------------------------------
    task automatic reset_test();
        logic [7:0] v;
        @(negedge clk);
        check_value("busy_o after reset", int'(busy_o), 0);
        read_reg(REG_X0, v);
        check_value("register 0 after reset", int'(v), 0);
        read_reg(REG_ONE, v);
        check_value("register 15 after reset", int'(v), 1);
        read_reg(REG_ZERO, v);
        check_value("register 14 after reset", int'(v), 0);
        report_test("reset state");
    endtask

    task automatic keygen_test(input logic [7:0] base, input logic [7:0] scalar);
        logic [7:0] got;
        string      name;
        name = $sformatf("keygen base=%0d scalar=%0d", base, scalar);
        load_operands(scalar, base, 8'd0);
        run_command(CMD_KEYGEN, -1, 3'd0);
        read_reg(REG_X0, got);
        check_value(name, int'(got), pow_mod(int'(base), int'(scalar)));
        report_test(name);
    endtask

    task automatic addsub_test(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] sum;
        logic [7:0] diff;
        int         ra;
        int         rb;
        string      name;
        name      = $sformatf("add/sub a=%0d b=%0d", a, b);
        ra        = int'(a) % P_MOD;   // Inputs are reduced on load
        rb        = int'(b) % P_MOD;
        last_sum  = (ra + rb) % P_MOD;
        last_diff = (ra - rb + P_MOD) % P_MOD;
        load_operands(8'd0, a, b);
        run_command(CMD_ADDSUB, -1, 3'd0);
        read_reg(REG_SUM, sum);
        read_reg(REG_DIFF, diff);
        check_value({name, " sum"}, int'(sum), last_sum);
        check_value({name, " diff"}, int'(diff), last_diff);
        report_test(name);
    endtask

    // Regs 4 and 5 keep the model results of the last add/sub step
    task automatic busy_ignore_test();
        logic [7:0] v;
        logic [7:0] base;
        logic [7:0] scalar;
        base   = rand_byte();
        scalar = rand_byte();
        load_operands(scalar, base, rand_byte());
        run_command(CMD_KEYGEN, 5, CMD_ADDSUB);
        read_reg(REG_X0, v);
        check_value("keygen with ignored command", int'(v),
                    pow_mod(int'(base), int'(scalar)));
        read_reg(REG_SUM, v);
        check_value("register 4 during busy", int'(v), last_sum);
        read_reg(REG_DIFF, v);
        check_value("register 5 during busy", int'(v), last_diff);
        report_test("command while busy");
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        seed      = 32'he33d;
        last_sum  = 0;
        last_diff = 0;
        reset_n   = 1'b0;
        cmd_i     = '0;
        load_i    = 1'b0;
        scalar_i  = '0;
        base_i    = '0;
        opb_i     = '0;
        rd_addr_i = '0;

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        reset_test();
        for (int i = 0; i < NUM_RANDOM_KEYGEN; i++)
            keygen_test(rand_byte(), rand_byte());
        keygen_test(rand_byte(), 8'd0);     // Empty exponent
        keygen_test(8'd0, 8'd255);
        keygen_test(8'd1, rand_byte());
        for (int i = 0; i < NUM_ADDSUB; i++)
            addsub_test(rand_byte(), rand_byte());
        busy_ignore_test();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/ecc_ladder_top.sv
`timescale 1ns/1ps

module ecc_ladder_top
    import ecc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [CMD_W-1:0]     cmd_i,
    input  logic                 load_i,
    input  logic [SCALAR_W-1:0]  scalar_i,
    input  logic [DATA_W-1:0]    base_i,
    input  logic [DATA_W-1:0]    opb_i,
    input  logic [RF_ADDR_W-1:0] rd_addr_i,
    output logic [DATA_W-1:0]    rd_data_o,
    output logic                 busy_o
);

    logic                   digit, last_digit, req_digit, start;
    logic                   ctrl_busy, alu_busy;
    logic [PROG_ADDR_W-1:0] prog_addr;
    logic [INSTR_W-1:0]     prog_line;
    logic [INSTR_W-1:0]     instr;

    ecc_scalar_feeder u_feeder (
        .clk          (clk),
        .reset_n      (reset_n),
        .load_i       (load_i),
        .scalar_i     (scalar_i),
        .start_i      (start),
        .req_digit_i  (req_digit),
        .digit_o      (digit),
        .last_digit_o (last_digit)
    );

    ecc_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_i        (cmd_i),
        .digit_i      (digit),
        .last_digit_i (last_digit),
        .prog_line_i  (prog_line),
        .prog_addr_o  (prog_addr),
        .start_o      (start),
        .req_digit_o  (req_digit),
        .instr_o      (instr),
        .busy_o       (ctrl_busy)
    );

    ecc_program_rom u_rom (
        .clk    (clk),
        .addr_i (prog_addr),
        .line_o (prog_line)
    );

    ecc_field_alu u_alu (
        .clk        (clk),
        .reset_n    (reset_n),
        .load_i     (load_i),
        .base_i     (base_i),
        .opb_i      (opb_i),
        .instr_i    (instr),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .alu_busy_o (alu_busy)
    );

    assign busy_o = ctrl_busy | alu_busy;   // Covers the final multiply

endmodule

// File: hw/ecc_field_alu.sv
`timescale 1ns/1ps

module ecc_field_alu
    import ecc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 load_i,
    input  logic [DATA_W-1:0]    base_i,
    input  logic [DATA_W-1:0]    opb_i,
    input  logic [INSTR_W-1:0]   instr_i,
    input  logic [RF_ADDR_W-1:0] rd_addr_i,
    output logic [DATA_W-1:0]    rd_data_o,
    output logic                 alu_busy_o
);

    localparam int MCNT_W = $clog2(SCALAR_W + 1);

    function automatic logic [DATA_W-1:0] mod_add(input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        logic [DATA_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= (DATA_W+1)'(FIELD_P))
            s = s - (DATA_W+1)'(FIELD_P);
        return s[DATA_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] mod_sub(input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        logic [DATA_W:0] d;
        if (a >= b)
            d = {1'b0, a} - {1'b0, b};
        else
            d = {1'b0, a} + (DATA_W+1)'(FIELD_P) - {1'b0, b};
        return d[DATA_W-1:0];
    endfunction

    // Raw inputs may exceed the prime by a few counts
    function automatic logic [DATA_W-1:0] reduce(input logic [DATA_W-1:0] v);
        return (v >= DATA_W'(FIELD_P)) ? v - DATA_W'(FIELD_P) : v;
    endfunction

    logic [DATA_W-1:0]    rf [0:REG_ZERO-1];  // 14 and 15 are constants
    logic [DATA_W-1:0]    src_a, src_b;
    logic [2:0]           opcode;
    logic [RF_ADDR_W-1:0] dst;

    logic                 mul_busy;
    logic [MCNT_W-1:0]    mul_cnt;
    logic [DATA_W-1:0]    mul_a;      // Multiplier, consumed MSB first
    logic [DATA_W-1:0]    mul_b;
    logic [DATA_W-1:0]    mul_acc;
    logic [RF_ADDR_W-1:0] mul_dst;

    assign opcode = instr_i[OPC_LSB +: 3];
    assign dst    = instr_i[DST_LSB +: RF_ADDR_W];

    always_comb begin
        case (instr_i[SRCA_LSB +: RF_ADDR_W])
            REG_ZERO : src_a = '0;
            REG_ONE  : src_a = DATA_W'(1);
            default  : src_a = rf[instr_i[SRCA_LSB +: RF_ADDR_W]];
        endcase
        case (instr_i[SRCB_LSB +: RF_ADDR_W])
            REG_ZERO : src_b = '0;
            REG_ONE  : src_b = DATA_W'(1);
            default  : src_b = rf[instr_i[SRCB_LSB +: RF_ADDR_W]];
        endcase
    end

    //------------------------------------------------------------
    // Register file and multiply sequencing
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < REG_ZERO; i++)
                rf[i] <= '0;
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
        end else begin
            if (load_i) begin
                rf[REG_BASE] <= reduce(base_i);
                rf[REG_OPB]  <= reduce(opb_i);
            end

            if (instr_i[WE_BIT] && dst < REG_ZERO) begin
                case (opcode)
                    ALU_ADD : rf[dst] <= mod_add(src_a, src_b);
                    ALU_SUB : rf[dst] <= mod_sub(src_a, src_b);
                    default : ;
                endcase
            end

            if (opcode == ALU_MUL) begin
                mul_busy <= 1'b1;
                mul_cnt  <= MCNT_W'(SCALAR_W);
            end else if (mul_busy) begin
                if (mul_cnt != '0) begin
                    mul_cnt <= mul_cnt - 1'b1;
                end else begin
                    mul_busy <= 1'b0;
                    if (mul_dst < REG_ZERO)
                        rf[mul_dst] <= mul_acc;   // Write back
                end
            end
        end
    end

    // Interleaved shift-add, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (opcode == ALU_MUL) begin
            mul_a   <= src_a;
            mul_b   <= src_b;
            mul_acc <= '0;
            mul_dst <= dst;
        end else if (mul_busy && mul_cnt != '0) begin
            mul_acc <= mod_add(mod_add(mul_acc, mul_acc),
                               mul_a[DATA_W-1] ? mul_b : '0);
            mul_a   <= {mul_a[DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            rd_data_o <= '0;
        else if (rd_addr_i == REG_ZERO)
            rd_data_o <= '0;
        else if (rd_addr_i == REG_ONE)
            rd_data_o <= DATA_W'(1);
        else
            rd_data_o <= rf[rd_addr_i];
    end

    assign alu_busy_o = mul_busy;

endmodule

// File: hw/ecc_ctrl.sv
`timescale 1ns/1ps

module ecc_ctrl
    import ecc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [CMD_W-1:0]       cmd_i,
    input  logic                   digit_i,
    input  logic                   last_digit_i,
    input  logic [INSTR_W-1:0]     prog_line_i,
    output logic [PROG_ADDR_W-1:0] prog_addr_o,
    output logic                   start_o,
    output logic                   req_digit_o,
    output logic [INSTR_W-1:0]     instr_o,
    output logic                   busy_o
);

    logic [PROG_ADDR_W-1:0] prog_cntr;
    logic [7:0]             hold_cntr;     // Stall or delay cycles left
    logic [7:0]             line_hold;
    logic                   line_vld;      // ROM output matches prog_cntr
    logic [1:0]             branch_pend;   // Waiting for the feeder to shift
    logic                   consume;
    logic [INSTR_W-1:0]     prog_line_pipe1;
    logic [INSTR_W-1:0]     prog_line_pipe2;

    assign prog_addr_o = prog_cntr;
    assign consume     = line_vld && (hold_cntr == '0) && (branch_pend == '0);

    // Fetch hold requested by the line now at the ROM output
    always_comb begin
        if (prog_line_i[STALL_BIT]) begin
            line_hold = prog_line_i[7:0];
        end else begin
            case (prog_line_i[OPC_LSB +: 3])
                OP_ADD, OP_SUB : line_hold = 8'(ADD_DELAY);
                OP_MUL         : line_hold = 8'(MULT_DELAY);
                default        : line_hold = '0;
            endcase
        end
    end

    //------------------------------------------------------------
    // Program sequencer
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prog_cntr   <= NOP_ADDR;
            hold_cntr   <= '0;
            line_vld    <= 1'b0;
            branch_pend <= '0;
            start_o     <= 1'b0;
            req_digit_o <= 1'b0;
        end else begin
            start_o     <= 1'b0;
            req_digit_o <= 1'b0;
            branch_pend <= {branch_pend[0], 1'b0};

            if (hold_cntr != '0)
                hold_cntr <= hold_cntr - 1'b1;

            if (branch_pend[1]) begin
                // Feeder has moved on, branch on the new digit
                prog_cntr <= digit_i ? LADDER1_S : LADDER0_S;
                line_vld  <= 1'b0;
            end else if (consume) begin
                hold_cntr <= line_hold;
                line_vld  <= 1'b0;
                case (prog_cntr)
                    NOP_ADDR : begin
                        case (cmd_i)
                            CMD_KEYGEN : begin
                                prog_cntr <= LADDER_INIT_S;
                                start_o   <= 1'b1;
                            end
                            CMD_ADDSUB : prog_cntr <= ADDSUB_S;
                            default    : line_vld  <= 1'b1;  // Keep draining
                        endcase
                    end
                    LADDER_INIT_E : prog_cntr <= digit_i ? LADDER1_S : LADDER0_S;
                    LADDER0_E, LADDER1_E : begin
                        if (last_digit_i) begin
                            prog_cntr <= NOP_ADDR;
                        end else begin
                            req_digit_o <= 1'b1;
                            branch_pend <= 2'b01;
                        end
                    end
                    ADDSUB_E : prog_cntr <= NOP_ADDR;
                    default  : prog_cntr <= prog_cntr + 1'b1;
                endcase
            end else if (branch_pend == '0) begin
                line_vld <= 1'b1;   // Fresh line arrives after one cycle
            end
        end
    end

    //------------------------------------------------------------
    // Line pipeline and issue
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prog_line_pipe1 <= '0;
            prog_line_pipe2 <= '0;
            instr_o         <= '0;
        end else if (consume) begin
            prog_line_pipe1 <= prog_line_i;
            prog_line_pipe2 <= prog_line_pipe1;
            instr_o         <= '0;
            if (!prog_line_pipe2[STALL_BIT]) begin   // Stall lines go out as NOP
                case (prog_line_pipe2[OPC_LSB +: 3])
                    OP_ADD  : instr_o[OPC_LSB +: 3] <= ALU_ADD;
                    OP_SUB  : instr_o[OPC_LSB +: 3] <= ALU_SUB;
                    OP_MUL  : instr_o[OPC_LSB +: 3] <= ALU_MUL;
                    default : instr_o[OPC_LSB +: 3] <= ALU_NOP;
                endcase
                instr_o[WE_BIT:0] <= prog_line_pipe2[WE_BIT:0];
            end
        end else begin
            instr_o <= '0;   // Each line issues once
        end
    end

    // Busy until the program and the pipeline have drained
    assign busy_o = (prog_cntr != NOP_ADDR) || (branch_pend != '0)
                 || (prog_line_pipe1 != '0) || (prog_line_pipe2 != '0)
                 || (instr_o != '0);

endmodule

// File: hw/ecc_program_rom.sv
`timescale 1ns/1ps

module ecc_program_rom
    import ecc_pkg::*;
(
    input  logic                   clk,
    input  logic [PROG_ADDR_W-1:0] addr_i,
    output logic [INSTR_W-1:0]     line_o
);

    // Builds one arithmetic line
    function automatic logic [INSTR_W-1:0] op_line(
        input logic [2:0]           op,
        input logic [RF_ADDR_W-1:0] dst,
        input logic [RF_ADDR_W-1:0] src_a,
        input logic [RF_ADDR_W-1:0] src_b
    );
        logic [INSTR_W-1:0] l;
        l = '0;
        l[OPC_LSB +: 3]           = op;
        l[WE_BIT]                 = 1'b1;
        l[DST_LSB +: RF_ADDR_W]   = dst;
        l[SRCA_LSB +: RF_ADDR_W]  = src_a;
        l[SRCB_LSB +: RF_ADDR_W]  = src_b;
        return l;
    endfunction

    // Stall line, wait count in the low byte
    function automatic logic [INSTR_W-1:0] stall_line(input logic [7:0] cnt);
        logic [INSTR_W-1:0] l;
        l            = '0;
        l[STALL_BIT] = 1'b1;
        l[7:0]       = cnt;
        return l;
    endfunction

    logic [INSTR_W-1:0] rom_data;

    always_comb begin
        case (addr_i)
            // Ladder init: X0 = 1, X1 = base
            LADDER_INIT_S : rom_data = op_line(OP_ADD, REG_X0, REG_ONE, REG_ZERO);
            LADDER_INIT_E : rom_data = op_line(OP_ADD, REG_X1, REG_BASE, REG_ZERO);

            // Digit 0
            LADDER0_S     : rom_data = op_line(OP_MUL, REG_X1, REG_X0, REG_X1);
            6'd4          : rom_data = op_line(OP_MUL, REG_X0, REG_X0, REG_X0);
            LADDER0_E     : rom_data = stall_line(8'(LADDER_STALL));

            // Digit 1
            LADDER1_S     : rom_data = op_line(OP_MUL, REG_X0, REG_X0, REG_X1);
            6'd7          : rom_data = op_line(OP_MUL, REG_X1, REG_X1, REG_X1);
            LADDER1_E     : rom_data = stall_line(8'(LADDER_STALL));

            // Add/sub step
            ADDSUB_S      : rom_data = op_line(OP_ADD, REG_SUM, REG_BASE, REG_OPB);
            6'd10         : rom_data = op_line(OP_SUB, REG_DIFF, REG_BASE, REG_OPB);
            ADDSUB_E      : rom_data = stall_line(8'(ADDSUB_STALL));

            default       : rom_data = '0;  // NOP_ADDR and unused space
        endcase
    end

    always_ff @(posedge clk) begin
        line_o <= rom_data;
    end

endmodule

// File: hw/ecc_scalar_feeder.sv
`timescale 1ns/1ps

module ecc_scalar_feeder
    import ecc_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                load_i,
    input  logic [SCALAR_W-1:0] scalar_i,
    input  logic                start_i,
    input  logic                req_digit_i,
    output logic                digit_o,
    output logic                last_digit_o
);

    localparam int CNT_W = $clog2(SCALAR_W);

    logic [SCALAR_W-1:0] scalar_q;  // Latched secret
    logic [SCALAR_W-1:0] work_q;    // Shifting copy
    logic [CNT_W-1:0]    cnt_q;     // Digits left after the current one

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scalar_q <= '0;
            work_q   <= '0;
            cnt_q    <= CNT_W'(SCALAR_W - 1);
        end else if (load_i) begin
            scalar_q <= scalar_i;
            work_q   <= scalar_i;
            cnt_q    <= CNT_W'(SCALAR_W - 1);
        end else if (start_i) begin
            work_q <= scalar_q;    // Restart from the latched value
            cnt_q  <= CNT_W'(SCALAR_W - 1);
        end else if (req_digit_i && cnt_q != '0) begin
            work_q <= {work_q[SCALAR_W-2:0], 1'b0};
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    assign digit_o      = work_q[SCALAR_W-1];  // MSB first
    assign last_digit_o = (cnt_q == '0);

endmodule

// File: hw/ecc_pkg.sv
package ecc_pkg;

    //------------------------------------------------------------
    // Field and data
    //------------------------------------------------------------
    localparam int FIELD_P     = 251;
    localparam int DATA_W      = 8;
    localparam int SCALAR_W    = 8;
    localparam int CMD_W       = 3;
    localparam int RF_ADDR_W   = 4;

    //------------------------------------------------------------
    // Instruction layout
    //------------------------------------------------------------
    localparam int INSTR_W     = 24;
    localparam int STALL_BIT   = 23;
    localparam int OPC_LSB     = 18;   // 3-bit opcode
    localparam int WE_BIT      = 17;
    localparam int DST_LSB     = 12;
    localparam int SRCA_LSB    = 8;
    localparam int SRCB_LSB    = 4;

    // Opcodes as stored in the ROM
    localparam logic [2:0] OP_NOP  = 3'd0;
    localparam logic [2:0] OP_ADD  = 3'd1;
    localparam logic [2:0] OP_SUB  = 3'd2;
    localparam logic [2:0] OP_MUL  = 3'd3;

    // Opcodes seen by the ALU
    localparam logic [2:0] ALU_NOP = 3'b000;
    localparam logic [2:0] ALU_ADD = 3'b010;
    localparam logic [2:0] ALU_SUB = 3'b011;
    localparam logic [2:0] ALU_MUL = 3'b100;

    // Extra fetch-hold cycles
    localparam int MULT_DELAY  = 9;
    localparam int ADD_DELAY   = 1;
    localparam int LADDER_STALL = 12;  // Covers the last multiply of a block
    localparam int ADDSUB_STALL = 2;

    //------------------------------------------------------------
    // Program addresses
    //------------------------------------------------------------
    localparam int PROG_ADDR_W = 6;
    localparam logic [PROG_ADDR_W-1:0] NOP_ADDR      = 6'd0;
    localparam logic [PROG_ADDR_W-1:0] LADDER_INIT_S = 6'd1;
    localparam logic [PROG_ADDR_W-1:0] LADDER_INIT_E = 6'd2;
    localparam logic [PROG_ADDR_W-1:0] LADDER0_S     = 6'd3;
    localparam logic [PROG_ADDR_W-1:0] LADDER0_E     = 6'd5;
    localparam logic [PROG_ADDR_W-1:0] LADDER1_S     = 6'd6;
    localparam logic [PROG_ADDR_W-1:0] LADDER1_E     = 6'd8;
    localparam logic [PROG_ADDR_W-1:0] ADDSUB_S      = 6'd9;
    localparam logic [PROG_ADDR_W-1:0] ADDSUB_E      = 6'd11;

    // Register map
    localparam logic [RF_ADDR_W-1:0] REG_X0   = 4'd0;
    localparam logic [RF_ADDR_W-1:0] REG_X1   = 4'd1;
    localparam logic [RF_ADDR_W-1:0] REG_BASE = 4'd2;
    localparam logic [RF_ADDR_W-1:0] REG_OPB  = 4'd3;
    localparam logic [RF_ADDR_W-1:0] REG_SUM  = 4'd4;
    localparam logic [RF_ADDR_W-1:0] REG_DIFF = 4'd5;
    localparam logic [RF_ADDR_W-1:0] REG_ZERO = 4'd14;
    localparam logic [RF_ADDR_W-1:0] REG_ONE  = 4'd15;

    // Commands
    localparam logic [CMD_W-1:0] CMD_KEYGEN = 3'd1;
    localparam logic [CMD_W-1:0] CMD_ADDSUB = 3'd2;

endpackage
